// File: common/capture_consts.svh
`ifndef CAPTURE_CONSTS_SVH
`define CAPTURE_CONSTS_SVH

// sample and packed word geometry
`define CAP_SAMPLE_W          12
`define CAP_SAMPLES_PER_WORD  3
`define CAP_WORD_W            36

// counter widths
`define CAP_COUNT_W           16
`define CAP_DOWNSAMPLE_W      13

// buffer depths
// the word buffer depth doubles as the packer's credit count
`define CAP_PRESAMPLE_DEPTH   256
`define CAP_WORD_FIFO_DEPTH   32

`endif

// File: common/capture_pkg.sv
`include "capture_consts.svh"

package capture_pkg;

    typedef logic [`CAP_SAMPLE_W-1:0]     sample_t;
    typedef logic [`CAP_WORD_W-1:0]       word_t;     // 3 samples with the oldest on top
    typedef logic [`CAP_COUNT_W-1:0]      count_t;
    typedef logic [`CAP_DOWNSAMPLE_W-1:0] downsample_t;
    typedef logic [7:0]                   byte_t;

    // one extra bit so a full buffer is representable
    typedef logic [$clog2(`CAP_PRESAMPLE_DEPTH):0] buf_level_t;
    typedef logic [$clog2(`CAP_WORD_FIFO_DEPTH):0] credit_t;

    typedef enum logic [2:0] {
        cap_idle,
        cap_presampling,
        cap_triggered,
        cap_filling_out,   // topping up to a whole word
        cap_done
    } capture_state_t;

endpackage

// File: common/buf_ctrl_if.sv
`timescale 1ns/100ps

interface buf_ctrl_if;

    logic                    push;        // store current adc sample
    logic                    drain;       // discard oldest sample
    logic                    forward_en;  // let stored samples go to packer
    capture_pkg::buf_level_t level;
    logic                    empty;

    modport ctrl (
        output push, drain, forward_en,
        input  level, empty
    );

    modport buffer (
        input  push, drain, forward_en,
        output level, empty
    );

endinterface

// File: capture/capture_ctrl.sv
`timescale 1ns/100ps

module capture_ctrl (
    input  logic                     adc_sampleclk,
    input  logic                     reset,
    input  logic                     arm_i,
    input  logic                     capture_go_i,
    input  logic                     adc_write_mask_i,
    input  capture_pkg::count_t      presample_i,
    input  capture_pkg::count_t      max_samples_i,
    input  capture_pkg::downsample_t downsample_i,
    buf_ctrl_if.ctrl                 bus,
    output logic                     capture_stop_o,
    output capture_pkg::count_t      samples_o
);

    capture_pkg::capture_state_t state;
    capture_pkg::downsample_t    ds_ctr;
    capture_pkg::count_t         sample_cnt;
    capture_pkg::count_t         level_ext;
    logic                        arm_r;
    logic                        arm_edge;
    logic                        keep;
    logic                        push_en;
    logic                        at_window;

    assign arm_edge  = arm_i & ~arm_r;
    assign keep      = adc_write_mask_i && (ds_ctr == downsample_i);
    assign level_ext = capture_pkg::count_t'(bus.level);
    assign at_window = (level_ext >= presample_i);

    always_comb begin
        case (state)
            capture_pkg::cap_presampling: push_en = (presample_i != '0);
            // no gap when the count reaches the limit mid-word
            capture_pkg::cap_triggered:   push_en = (sample_cnt < max_samples_i)
                                                    || ((sample_cnt % 3) != 0);
            capture_pkg::cap_filling_out: push_en = ((sample_cnt % 3) != 0);
            default:                      push_en = 1'b0;
        endcase
    end

    assign bus.push  = push_en & keep;
    // once P samples are held each new one evicts the oldest
    assign bus.drain = bus.push && (state == capture_pkg::cap_presampling) && at_window;

    assign samples_o = sample_cnt;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state          <= capture_pkg::cap_idle;
            arm_r          <= 1'b0;
            ds_ctr         <= '0;
            sample_cnt     <= '0;
            bus.forward_en <= 1'b0;
            capture_stop_o <= 1'b0;
        end else begin
            arm_r <= arm_i;

            // skip counter only advances on unmasked samples
            if (arm_edge)
                ds_ctr <= '0;
            else if (adc_write_mask_i)
                ds_ctr <= (ds_ctr == downsample_i) ? '0 : ds_ctr + 1'b1;

            case (state)
                capture_pkg::cap_idle,
                capture_pkg::cap_done: begin
                    if (arm_edge) begin
                        state          <= capture_pkg::cap_presampling;
                        sample_cnt     <= '0;
                        bus.forward_en <= 1'b0;
                        capture_stop_o <= 1'b0;
                    end else if (state == capture_pkg::cap_done && bus.empty) begin
                        capture_stop_o <= 1'b1;  // held until next arm
                    end
                end
                capture_pkg::cap_presampling: begin
                    if (capture_go_i) begin
                        state          <= capture_pkg::cap_triggered;
                        bus.forward_en <= 1'b1;
                        // level as it will be after this cycle's push/drain
                        sample_cnt     <= level_ext
                                          + capture_pkg::count_t'(bus.push && !bus.drain);
                    end
                end
                capture_pkg::cap_triggered: begin
                    if (bus.push)
                        sample_cnt <= sample_cnt + 1'b1;
                    if (sample_cnt >= max_samples_i)
                        state <= capture_pkg::cap_filling_out;
                end
                capture_pkg::cap_filling_out: begin
                    if (bus.push)
                        sample_cnt <= sample_cnt + 1'b1;
                    if ((sample_cnt % 3) == 0)
                        state <= capture_pkg::cap_done;
                end
                default: state <= capture_pkg::cap_idle;
            endcase
        end
    end

    a_no_drain_empty: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        bus.drain |-> !bus.empty
    );

    a_forward_state: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        bus.forward_en |-> state inside {capture_pkg::cap_triggered,
                                         capture_pkg::cap_filling_out,
                                         capture_pkg::cap_done}
    );

endmodule

// File: capture/presample_buffer.sv
`timescale 1ns/100ps
`include "capture_consts.svh"

module presample_buffer (
    input  logic                 adc_sampleclk,
    input  logic                 reset,
    input  capture_pkg::sample_t adc_data_i,
    buf_ctrl_if.buffer           bus,
    output logic                 sample_valid_o,
    output capture_pkg::sample_t sample_data_o,
    input  logic                 sample_ready_i,
    output logic                 overflow_o
);

    capture_pkg::sample_t                      mem [`CAP_PRESAMPLE_DEPTH];
    logic [$clog2(`CAP_PRESAMPLE_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(`CAP_PRESAMPLE_DEPTH)-1:0]   rd_ptr;
    logic                                      full;
    logic                                      wr;
    logic                                      rd;

    assign full      = (bus.level == `CAP_PRESAMPLE_DEPTH);
    assign bus.empty = (bus.level == '0);
    assign wr        = bus.push & ~full;   // push into a full buffer is lost

    assign sample_valid_o = bus.forward_en & ~bus.empty;
    assign sample_data_o  = mem[rd_ptr];
    assign rd = bus.drain | (sample_valid_o & sample_ready_i);

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            bus.level  <= '0;
            overflow_o <= 1'b0;
        end else begin
            overflow_o <= bus.push & full;
            if (wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd)
                rd_ptr <= rd_ptr + 1'b1;
            if (wr && !rd)
                bus.level <= bus.level + 1'b1;
            else if (rd && !wr)
                bus.level <= bus.level - 1'b1;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (wr)
            mem[wr_ptr] <= adc_data_i;
    end

    a_level_bound: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        bus.level <= `CAP_PRESAMPLE_DEPTH
    );

endmodule

// File: capture/sample_packer.sv
`timescale 1ns/100ps
`include "capture_consts.svh"

module sample_packer (
    input  logic                 adc_sampleclk,
    input  logic                 reset,
    input  logic                 arm_i,
    input  logic                 sample_valid_i,
    input  capture_pkg::sample_t sample_data_i,
    output logic                 sample_ready_o,
    output logic                 word_valid_o,
    output capture_pkg::word_t   word_data_o,
    input  logic                 credit_return_i
);

    capture_pkg::credit_t credits;
    logic [1:0]           fill;      // samples in the current word
    logic                 arm_r;
    logic                 arm_edge;
    logic                 accept;
    logic                 word_end;

    assign arm_edge       = arm_i & ~arm_r;
    assign sample_ready_o = (credits != '0);
    assign accept         = sample_valid_i & sample_ready_o;
    assign word_end       = accept && (fill == 2'(`CAP_SAMPLES_PER_WORD - 1));

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            arm_r        <= 1'b0;
            fill         <= '0;
            word_valid_o <= 1'b0;
            credits      <= capture_pkg::credit_t'(`CAP_WORD_FIFO_DEPTH);
        end else begin
            arm_r        <= arm_i;
            word_valid_o <= word_end;
            if (arm_edge) begin
                fill    <= '0;
                credits <= capture_pkg::credit_t'(`CAP_WORD_FIFO_DEPTH);
            end else begin
                if (accept)
                    fill <= word_end ? 2'd0 : fill + 2'd1;
                // credit is spent on the cycle the word leaves
                credits <= credits + capture_pkg::credit_t'(credit_return_i)
                                   - capture_pkg::credit_t'(word_valid_o);
            end
        end
    end

    // oldest sample ends up in the top bits
    always_ff @(posedge adc_sampleclk) begin
        if (accept)
            word_data_o <= {word_data_o[`CAP_WORD_W-`CAP_SAMPLE_W-1:0], sample_data_i};
    end

    a_word_has_credit: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        word_valid_o |-> credits != '0
    );

endmodule

// File: readout/word_fifo.sv
`timescale 1ns/100ps
`include "capture_consts.svh"

module word_fifo (
    input  logic               adc_sampleclk,
    input  logic               reset,
    input  logic               word_valid_i,
    input  capture_pkg::word_t word_data_i,
    input  logic               pop_i,
    output capture_pkg::word_t head_o,
    output logic               empty_o,
    output logic               credit_return_o
);

    capture_pkg::word_t                      mem [`CAP_WORD_FIFO_DEPTH];
    logic [$clog2(`CAP_WORD_FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(`CAP_WORD_FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(`CAP_WORD_FIFO_DEPTH):0]   count;
    logic                                    pop;

    assign empty_o = (count == '0);
    assign pop     = pop_i & ~empty_o;
    assign head_o  = mem[rd_ptr];     // show-ahead

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            wr_ptr          <= '0;
            rd_ptr          <= '0;
            count           <= '0;
            credit_return_o <= 1'b0;
        end else begin
            credit_return_o <= pop;   // one credit back per word popped
            if (word_valid_i)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (word_valid_i && !pop)
                count <= count + 1'b1;
            else if (pop && !word_valid_i)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (word_valid_i)
            mem[wr_ptr] <= word_data_i;
    end

    a_no_write_full: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        word_valid_i |-> count != `CAP_WORD_FIFO_DEPTH
    );

endmodule

// File: readout/byte_serializer.sv
`timescale 1ns/100ps

module byte_serializer (
    input  logic               adc_sampleclk,
    input  logic               reset,
    input  logic               arm_i,
    input  logic               low_res_i,
    input  logic               low_res_lsb_i,
    input  logic               rd_en_i,
    input  capture_pkg::word_t head_i,
    input  logic               empty_i,
    output logic               pop_o,
    output capture_pkg::byte_t rd_data_o,
    output logic               error_flag_o,
    input  logic               overflow_i
);

    logic                 arm_r;
    logic                 arm_edge;
    logic                 rd;
    logic                 wrap;
    logic [3:0]           idx;       // byte position within 1 or 2 words
    logic [3:0]           nib_q;     // low nibble of first word in full-res
    capture_pkg::sample_t lr_sample;
    capture_pkg::byte_t   byte_d;

    assign arm_edge = arm_i & ~arm_r;
    assign rd       = rd_en_i & ~empty_i;
    assign wrap     = low_res_i ? (idx == 4'd2) : (idx == 4'd8);
    assign pop_o    = rd && (wrap || (!low_res_i && idx == 4'd3));

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            arm_r        <= 1'b0;
            idx          <= '0;
            error_flag_o <= 1'b0;
        end else begin
            arm_r <= arm_i;
            if (arm_edge)
                idx <= '0;
            else if (rd)
                idx <= wrap ? 4'd0 : idx + 4'd1;
            if (arm_edge)
                error_flag_o <= 1'b0;
            else if ((rd_en_i && empty_i) || overflow_i)
                error_flag_o <= 1'b1;   // sticky
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (rd && !low_res_i && idx == 4'd3)
            nib_q <= head_i[3:0];
    end

    always_comb begin
        case (idx[1:0])
            2'd0:    lr_sample = head_i[35:24];
            2'd1:    lr_sample = head_i[23:12];
            default: lr_sample = head_i[11:0];
        endcase
        if (low_res_i) begin
            byte_d = low_res_lsb_i ? lr_sample[7:0] : lr_sample[11:4];
        end else begin
            case (idx)
                4'd0:    byte_d = head_i[35:28];
                4'd1:    byte_d = head_i[27:20];
                4'd2:    byte_d = head_i[19:12];
                4'd3:    byte_d = head_i[11:4];
                4'd4:    byte_d = {nib_q, head_i[35:32]};  // straddles two words
                4'd5:    byte_d = head_i[31:24];
                4'd6:    byte_d = head_i[23:16];
                4'd7:    byte_d = head_i[15:8];
                default: byte_d = head_i[7:0];
            endcase
        end
    end

    assign rd_data_o = error_flag_o ? '0 : byte_d;

endmodule

// File: src/capture_top.sv
`timescale 1ns/100ps
`include "capture_consts.svh"

module capture_top (
    input  logic                         adc_sampleclk,
    input  logic                         reset,
    input  logic [`CAP_SAMPLE_W-1:0]     adc_data_i,
    input  logic                         adc_write_mask_i,
    input  logic                         arm_i,
    input  logic                         capture_go_i,
    input  logic [`CAP_COUNT_W-1:0]      presample_i,
    input  logic [`CAP_COUNT_W-1:0]      max_samples_i,
    input  logic [`CAP_DOWNSAMPLE_W-1:0] downsample_i,
    input  logic                         low_res_i,
    input  logic                         low_res_lsb_i,
    input  logic                         rd_en_i,
    output logic [7:0]                   rd_data_o,
    output logic                         rd_empty_o,
    output logic                         capture_stop_o,
    output logic [`CAP_COUNT_W-1:0]      samples_o,
    output logic                         error_flag_o
);

    logic                     sample_valid;
    logic                     sample_ready;
    logic [`CAP_SAMPLE_W-1:0] sample_data;
    logic                     word_valid;
    logic [`CAP_WORD_W-1:0]   word_data;
    logic                     credit_return;
    logic [`CAP_WORD_W-1:0]   head;
    logic                     pop;
    logic                     overflow;

    buf_ctrl_if bus_if ();

    capture_ctrl u_capture_ctrl (
        .adc_sampleclk    (adc_sampleclk),
        .reset            (reset),
        .arm_i            (arm_i),
        .capture_go_i     (capture_go_i),
        .adc_write_mask_i (adc_write_mask_i),
        .presample_i      (presample_i),
        .max_samples_i    (max_samples_i),
        .downsample_i     (downsample_i),
        .bus              (bus_if.ctrl),
        .capture_stop_o   (capture_stop_o),
        .samples_o        (samples_o)
    );

    presample_buffer u_presample_buffer (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .adc_data_i     (adc_data_i),
        .bus            (bus_if.buffer),
        .sample_valid_o (sample_valid),
        .sample_data_o  (sample_data),
        .sample_ready_i (sample_ready),
        .overflow_o     (overflow)
    );

    sample_packer u_sample_packer (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .arm_i           (arm_i),
        .sample_valid_i  (sample_valid),
        .sample_data_i   (sample_data),
        .sample_ready_o  (sample_ready),
        .word_valid_o    (word_valid),
        .word_data_o     (word_data),
        .credit_return_i (credit_return)
    );

    word_fifo u_word_fifo (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .word_valid_i    (word_valid),
        .word_data_i     (word_data),
        .pop_i           (pop),
        .head_o          (head),
        .empty_o         (rd_empty_o),
        .credit_return_o (credit_return)
    );

    byte_serializer u_byte_serializer (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .arm_i         (arm_i),
        .low_res_i     (low_res_i),
        .low_res_lsb_i (low_res_lsb_i),
        .rd_en_i       (rd_en_i),
        .head_i        (head),
        .empty_i       (rd_empty_o),
        .pop_o         (pop),
        .rd_data_o     (rd_data_o),
        .error_flag_o  (error_flag_o),
        .overflow_i    (overflow)
    );

endmodule

// File: tests/capture_tb.sv
`timescale 1ns/100ps
`include "capture_consts.svh"

module capture_tb;

    localparam int clk_half_ns  = 4;
    localparam int reset_cycles = 8;
    // cycle budget per test
    // the downsample case is sized for the largest skip count
    localparam int reset_budget = 20;
    localparam int basic_budget = 400;
    localparam int ds_budget    = 1300;
    localparam int pre_budget   = 500;
    localparam int lowres_budget = 600;
    localparam int bp_budget    = 900;
    localparam int err_budget   = 300;
    localparam int margin       = 3;
    localparam int run_cycles   = reset_cycles + reset_budget + basic_budget + ds_budget
                                  + pre_budget + lowres_budget + bp_budget + err_budget;
    localparam int wait_limit   = 2000;   // max cycles spent waiting on the DUT

    logic                     adc_sampleclk;
    logic                     reset;
    capture_pkg::sample_t     adc_data_i;
    logic                     adc_write_mask_i;
    logic                     arm_i;
    logic                     capture_go_i;
    capture_pkg::count_t      presample_i;
    capture_pkg::count_t      max_samples_i;
    capture_pkg::downsample_t downsample_i;
    logic                     low_res_i;
    logic                     low_res_lsb_i;
    logic                     rd_en_i;
    capture_pkg::byte_t       rd_data_o;
    logic                     rd_empty_o;
    logic                     capture_stop_o;
    capture_pkg::count_t      samples_o;
    logic                     error_flag_o;

    int                   err_cnt;
    int                   test_err_start;
    int                   pass_tests;
    int                   fail_tests;
    string                test_name;
    logic [15:0]          lfsr;
    capture_pkg::sample_t trig_val;     // ramp value sampled at the trigger edge
    capture_pkg::byte_t   rx_bytes[$];
    capture_pkg::sample_t rx_samples[$];

    capture_top dut_i (.*);

    always #clk_half_ns adc_sampleclk = ~adc_sampleclk;

    // reference ramp of one step per clock
    always @(posedge adc_sampleclk) begin
        #1;
        adc_data_i <= adc_data_i + 1'b1;
    end

    a_empty_read_flags: assert property (@(posedge adc_sampleclk) disable iff (reset)
        (rd_en_i && rd_empty_o) |=> error_flag_o)
        else begin
            $display("%s: read of an empty buffer did not set error_flag_o", test_name);
            err_cnt++;
        end

    a_flag_zeroes_data: assert property (@(posedge adc_sampleclk) disable iff (reset)
        error_flag_o |-> (rd_data_o == '0))
        else begin
            $display("%s: rd_data_o not zero while error_flag_o is set", test_name);
            err_cnt++;
        end

    a_flag_stays_low: assert property (@(posedge adc_sampleclk) disable iff (reset)
        (!error_flag_o && !(rd_en_i && rd_empty_o)) |=> !error_flag_o)
        else begin
            $display("%s: error_flag_o rose without an empty read", test_name);
            err_cnt++;
        end

    a_arm_clears_flag: assert property (@(posedge adc_sampleclk) disable iff (reset)
        $rose(arm_i) |=> !error_flag_o)
        else begin
            $display("%s: arm did not clear error_flag_o", test_name);
            err_cnt++;
        end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    task automatic take_bits(input int n, output int val);
        int i;
        val = 0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);   // one step per bit
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic int round_up3(input int n);
        return (n + 2) / 3 * 3;
    endfunction

    task automatic next_cycle();
        @(posedge adc_sampleclk);
        #1;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (expected == actual)
        else begin
            $display("** Error %s: %s expected %0d, actual %0d",
                     test_name, what, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic report_fail(input string msg);
        $display("%s: %s", test_name, msg);
        err_cnt++;
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        test_err_start = err_cnt;
    endtask

    task automatic finish_test();
        if (err_cnt == test_err_start) begin
            pass_tests++;
            $display("[%s] ok", test_name);
        end else begin
            fail_tests++;
            $display("[%s] %0d errors", test_name, err_cnt - test_err_start);
        end
    endtask

    task automatic arm_capture(input int presample, input int max_samples, input int ds);
        presample_i   = capture_pkg::count_t'(presample);
        max_samples_i = capture_pkg::count_t'(max_samples);
        downsample_i  = capture_pkg::downsample_t'(ds);
        arm_i = 1'b1;
        next_cycle();
        arm_i = 1'b0;
    endtask

    task automatic trigger_capture(input int delay);
        wait_cycles(delay);
        capture_go_i = 1'b1;
        @(posedge adc_sampleclk);
        trig_val = adc_data_i;
        #1;
        capture_go_i = 1'b0;
    endtask

    task automatic wait_stop(output bit ok);
        int n;
        n = 0;
        while (!capture_stop_o && n < wait_limit) begin
            next_cycle();
            n++;
        end
        ok = capture_stop_o;
        if (!ok)
            report_fail("capture_stop_o never rose");
    endtask

    task automatic read_bytes(input int n);
        int idle;
        rx_bytes.delete();
        idle = 0;
        while (rx_bytes.size() < n && idle < wait_limit) begin
            if (!rd_empty_o) begin
                rx_bytes.push_back(rd_data_o);   // taken on the next edge
                rd_en_i = 1'b1;
                idle    = 0;
            end else begin
                rd_en_i = 1'b0;
                idle++;
            end
            next_cycle();
        end
        rd_en_i = 1'b0;
        if (rx_bytes.size() < n)
            report_fail("word buffer stayed empty before all bytes were read");
    endtask

    // 9 bytes carry 6 samples big-endian
    function automatic void unpack_full();
        int                 i;
        int                 k;
        capture_pkg::byte_t b[9];
        rx_samples.delete();
        for (i = 0; i + 9 <= rx_bytes.size(); i += 9) begin
            for (k = 0; k < 9; k++)
                b[k] = rx_bytes[i + k];
            rx_samples.push_back({b[0], b[1][7:4]});
            rx_samples.push_back({b[1][3:0], b[2]});
            rx_samples.push_back({b[3], b[4][7:4]});
            rx_samples.push_back({b[4][3:0], b[5]});
            rx_samples.push_back({b[6], b[7][7:4]});
            rx_samples.push_back({b[7][3:0], b[8]});
        end
    endfunction

    task automatic check_ramp(input int step);
        int k;
        int diff;
        for (k = 1; k < rx_samples.size(); k++) begin
            diff = int'(capture_pkg::sample_t'(rx_samples[k] - rx_samples[k-1]));
            if (diff != step) begin
                check_value($sformatf("ramp step at sample %0d", k), step, diff);
                break;
            end
        end
    endtask

    // full-res capture with a whole number of word pairs
    task automatic run_full_res(input int presample, input int max_samples, input int ds,
                                input int delay, input int step);
        bit ok;
        int expected;
        expected  = round_up3(max_samples);
        low_res_i = 1'b0;
        arm_capture(presample, max_samples, ds);
        trigger_capture(delay);
        wait_stop(ok);
        if (ok) begin
            check_value("rd_empty_o after capture", 0, rd_empty_o);
            check_value("samples_o", expected, samples_o);
            read_bytes(expected * 3 / 2);
            unpack_full();
            check_value("decoded sample count", expected, rx_samples.size());
            check_ramp(step);
        end
    endtask

    task automatic test_reset();
        begin_test("reset");
        check_value("capture_stop_o", 0, capture_stop_o);
        check_value("error_flag_o", 0, error_flag_o);
        check_value("rd_empty_o", 1, rd_empty_o);
        finish_test();
    endtask

    task automatic test_downsample();
        int ds;
        int dly;
        begin_test("downsample");
        take_bits(4, ds);
        take_bits(3, dly);
        run_full_res(0, 58, ds, 2 + dly, ds + 1);
        finish_test();
    endtask

    task automatic test_presample();
        int dly;
        int diff;
        begin_test("presample");
        take_bits(5, dly);
        run_full_res(20, 70, 0, 60 + dly, 1);
        if (rx_samples.size() > 0) begin
            diff = int'(capture_pkg::sample_t'(trig_val - rx_samples[0]));
            assert (diff >= 18 && diff <= 22)
            else begin
                $display("** Error %s: presample depth expected %0d, actual %0d",
                         test_name, 20, diff);
                err_cnt++;
            end
        end
        finish_test();
    endtask

    task automatic test_low_res(input bit lsb);
        bit                   ok;
        int                   dly;
        int                   k;
        capture_pkg::sample_t s;
        capture_pkg::byte_t   exp_b;
        begin_test(lsb ? "low_res_lsb" : "low_res_msb");
        take_bits(3, dly);
        low_res_i     = 1'b1;
        low_res_lsb_i = lsb;
        arm_capture(0, 30, 0);
        trigger_capture(2 + dly);
        wait_stop(ok);
        if (ok) begin
            read_bytes(30);
            for (k = 0; k < rx_bytes.size(); k++) begin
                s     = trig_val + capture_pkg::sample_t'(1 + k);  // first push follows trigger
                exp_b = lsb ? s[7:0] : s[11:4];
                if (rx_bytes[k] != exp_b) begin
                    check_value($sformatf("byte %0d", k), exp_b, rx_bytes[k]);
                    break;
                end
            end
        end
        low_res_i     = 1'b0;
        low_res_lsb_i = 1'b0;
        finish_test();
    endtask

    task automatic test_back_pressure();
        bit ok;
        begin_test("back_pressure");
        low_res_i = 1'b0;
        arm_capture(0, 208, 0);
        trigger_capture(3);
        wait_cycles(250);   // all pushes done and buffers stalled
        check_value("capture_stop_o while stalled", 0, capture_stop_o);
        read_bytes(315);
        wait_stop(ok);
        check_value("samples_o", round_up3(208), samples_o);
        unpack_full();
        check_value("decoded sample count", 210, rx_samples.size());
        check_ramp(1);
        check_value("error_flag_o", 0, error_flag_o);
        finish_test();
    endtask

    task automatic test_error_flag();
        bit ok;
        int k;
        begin_test("error_flag");
        low_res_i = 1'b0;
        arm_capture(0, 6, 0);
        check_value("rd_empty_o before trigger", 1, rd_empty_o);
        rd_en_i = 1'b1;   // read with nothing stored
        next_cycle();
        rd_en_i = 1'b0;
        check_value("error_flag_o after empty read", 1, error_flag_o);
        trigger_capture(2);
        wait_stop(ok);
        if (ok) begin
            read_bytes(9);
            for (k = 0; k < rx_bytes.size(); k++)
                check_value($sformatf("byte %0d with flag set", k), 0, rx_bytes[k]);
        end
        arm_capture(0, 6, 0);
        check_value("error_flag_o after arm", 0, error_flag_o);
        finish_test();
    endtask

    initial begin
        adc_sampleclk    = 1'b0;
        reset            = 1'b1;
        adc_data_i       = '0;
        adc_write_mask_i = 1'b1;
        arm_i            = 1'b0;
        capture_go_i     = 1'b0;
        presample_i      = '0;
        max_samples_i    = '0;
        downsample_i     = '0;
        low_res_i        = 1'b0;
        low_res_lsb_i    = 1'b0;
        rd_en_i          = 1'b0;
        err_cnt          = 0;
        test_err_start   = 0;
        pass_tests       = 0;
        fail_tests       = 0;
        test_name        = "init";
        lfsr             = 16'd6;

        repeat (reset_cycles) @(posedge adc_sampleclk);
        #1;
        reset = 1'b0;
        next_cycle();

        test_reset();
        begin_test("basic");
        run_full_res(0, 88, 0, 4, 1);
        finish_test();
        test_downsample();
        test_presample();
        test_low_res(1'b0);
        test_low_res(1'b1);
        test_back_pressure();
        test_error_flag();

        $display("summary: %0d tests ok, %0d tests with errors", pass_tests, fail_tests);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(run_cycles * margin * 2 * clk_half_ns);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+common
common/capture_pkg.sv
common/buf_ctrl_if.sv
capture/capture_ctrl.sv
capture/presample_buffer.sv
capture/sample_packer.sv
readout/word_fifo.sv
readout/byte_serializer.sv
src/capture_top.sv
tests/capture_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module capture_tb -f vlog.f \
    -o capture_sim || exit 1
./obj_dir/capture_sim > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0
